/* Makefile */
TOP := tb_exec_backend
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)
	verilator --lint-only -f verilog.f --top-module exec_backend

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/exec_backend_checker.sv */
`timescale 1ns/100ps

module exec_backend_checker (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_branch,
    input logic       i_jump,
    input logic       i_pcsrc,                         // DUT redirect
    input logic       i_wb_en,
    input logic [4:0] i_wb_rd
);

    int fail_count = 0;                                // Failed assertions so far

    // Writeback quiet while reset is held
    reset_wb_low: assert property (@(posedge i_clk) !i_rst_n |-> !i_wb_en)
        else begin
            $error("o_wb_en high during reset");
            fail_count++;
        end

    // Issuer never writes x0 with regwrite set
    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_en |-> (i_wb_rd != 5'd0))
        else begin
            $error("o_wb_rd is zero while o_wb_en is high");
            fail_count++;
        end

    // No redirect without branch or jump
    pcsrc_needs_ctrl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_branch && !i_jump) |-> !i_pcsrc)
        else begin
            $error("o_pcsrc high with branch and jump low");
            fail_count++;
        end

endmodule

bind exec_backend exec_backend_checker checker_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_branch (i_branch),
    .i_jump   (i_jump),
    .i_pcsrc  (o_pcsrc),
    .i_wb_en  (o_wb_en),
    .i_wb_rd  (o_wb_rd)
);

/* bench/exec_backend_monitor.sv */
`timescale 1ns/100ps

module exec_backend_monitor #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10,
    parameter int MEM_WORDS  = 256
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [4:0]             i_rs1_addr,
    input  logic [4:0]             i_rs2_addr,
    input  logic [4:0]             i_rd_addr,
    input  logic [DATA_WIDTH-1:0]  i_immext,
    input  logic [ADDR_WIDTH-1:0]  i_pc4,
    input  riscv_pkg::alu_op_t     i_aluctrl,
    input  logic                   i_alusrc,
    input  logic                   i_regwrite,
    input  logic                   i_memwrite,
    input  riscv_pkg::result_src_t i_resultsrc,
    input  logic                   i_row_valid,        // Issue comes from the table
    input  logic                   i_exp_pcsrc,
    input  logic [ADDR_WIDTH-1:0]  i_exp_pctarget,
    input  logic                   i_pcsrc,            // DUT outputs from here on
    input  logic [ADDR_WIDTH-1:0]  i_pctarget,
    input  logic                   i_wb_en,
    input  logic [4:0]             i_wb_rd,
    input  logic [DATA_WIDTH-1:0]  i_wb_data,
    output int                     o_errors,
    output int                     o_checks,
    output logic                   o_pending           // Writebacks still in flight
);

    logic [DATA_WIDTH-1:0] regs [32];                  // Architectural register model
    logic [DATA_WIDTH-1:0] mem [int];                  // Word index to data
    logic                  s1_v;                       // Issued one edge ago
    logic                  s1_en;
    logic [4:0]            s1_rd;
    logic [DATA_WIDTH-1:0] s1_data;
    logic                  s2_v;                       // Issued two edges ago
    logic                  s2_en;
    logic [4:0]            s2_rd;
    logic [DATA_WIDTH-1:0] s2_data;

    initial begin
        o_errors  = 0;
        o_checks  = 0;
        o_pending = 1'b0;
        s1_v      = 1'b0;
        s2_v      = 1'b0;
    end

    // RV32I semantics, shifts by low five bits
    function automatic logic [DATA_WIDTH-1:0] model_alu(input riscv_pkg::alu_op_t op,
                                                        input logic [DATA_WIDTH-1:0] a,
                                                        input logic [DATA_WIDTH-1:0] b);
        case (op)
            riscv_pkg::ALU_ADD:  return a + b;
            riscv_pkg::ALU_SUB:  return a - b;
            riscv_pkg::ALU_AND:  return a & b;
            riscv_pkg::ALU_OR:   return a | b;
            riscv_pkg::ALU_XOR:  return a ^ b;
            riscv_pkg::ALU_SLL:  return a << b[4:0];
            riscv_pkg::ALU_SRL:  return a >> b[4:0];
            riscv_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            riscv_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            riscv_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
            default:             return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [DATA_WIDTH-1:0] got,
                           input logic [DATA_WIDTH-1:0] exp);
        o_checks++;
        if (got !== exp) begin
            o_errors++;
            $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge i_clk) begin
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] res;
        int                    widx;
        if (!i_rst_n) begin
            compare("o_wb_en", i_wb_en, '0);           // Reset clears writeback
            compare("o_wb_rd", i_wb_rd, '0);
            compare("o_wb_data", i_wb_data, '0);
            foreach (regs[i]) regs[i] = '0;
            s1_v = 1'b0;
            s2_v = 1'b0;
        end else begin
            if (s2_v) begin                            // Writeback two cycles after issue
                compare("o_wb_en", i_wb_en, s2_en);
                if (s2_en) begin
                    compare("o_wb_rd", i_wb_rd, s2_rd);
                    compare("o_wb_data", i_wb_data, s2_data);
                end
            end
            if (i_row_valid) begin                     // Redirect valid in issue cycle
                compare("o_pcsrc", i_pcsrc, i_exp_pcsrc);
                compare("o_pctarget", i_pctarget, i_exp_pctarget);
            end
            a    = regs[i_rs1_addr];
            b    = i_alusrc ? i_immext : regs[i_rs2_addr];
            res  = model_alu(i_aluctrl, a, b);
            widx = (res >> 2) % MEM_WORDS;
            s2_v    = s1_v;
            s2_en   = s1_en;
            s2_rd   = s1_rd;
            s2_data = s1_data;
            s1_v    = i_row_valid;
            s1_en   = i_regwrite;
            s1_rd   = i_rd_addr;
            case (i_resultsrc)
                riscv_pkg::RES_MEM: s1_data = mem.exists(widx) ? mem[widx] : 'x;
                riscv_pkg::RES_PC4: s1_data = DATA_WIDTH'(i_pc4);
                default:            s1_data = res;
            endcase
            if (i_memwrite) mem[widx] = regs[i_rs2_addr];   // Store data is rs2
            if (i_regwrite && i_rd_addr != 5'd0) regs[i_rd_addr] = s1_data;
        end
        o_pending = s1_v | s2_v;
    end

endmodule

/* bench/tb_exec_backend.sv */
`timescale 1ns/100ps

module tb_exec_backend;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 10;
    localparam int MEM_WORDS  = 256;

    typedef struct {
        riscv_pkg::alu_op_t     op;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
        logic [DATA_WIDTH-1:0]  imm;
        logic                   alusrc;
        logic                   branch;
        logic                   jump;
        logic                   regwrite;
        logic                   memwrite;
        riscv_pkg::result_src_t rsrc;
        logic                   exp_pcsrc;             // Expected redirect
    } row_t;

    logic i_clk;
    logic i_rst_n;
    logic [4:0] i_rs1_addr;
    logic [4:0] i_rs2_addr;
    logic [4:0] i_rd_addr;
    logic [DATA_WIDTH-1:0] i_immext;
    logic [ADDR_WIDTH-1:0] i_pc;
    logic [ADDR_WIDTH-1:0] i_pc4;
    riscv_pkg::alu_op_t i_aluctrl;
    logic i_alusrc;
    logic i_branch;
    logic i_jump;
    logic i_regwrite;
    logic i_memwrite;
    riscv_pkg::result_src_t i_resultsrc;
    logic o_pcsrc;
    logic [ADDR_WIDTH-1:0] o_pctarget;
    logic o_wb_en;
    logic [4:0] o_wb_rd;
    logic [DATA_WIDTH-1:0] o_wb_data;
    logic row_valid;                                   // Current issue is a table row
    logic exp_pcsrc;
    logic [ADDR_WIDTH-1:0] exp_pctarget;               // PC plus immediate, PC width
    int errors;
    int checks;
    logic pending;
    row_t rows[$];
    int wait_cnt;

    exec_backend #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) exec_backend_inst (.*);

    exec_backend_monitor #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) monitor_inst (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_rs1_addr (i_rs1_addr),
        .i_rs2_addr (i_rs2_addr), .i_rd_addr (i_rd_addr), .i_immext (i_immext),
        .i_pc4 (i_pc4), .i_aluctrl (i_aluctrl), .i_alusrc (i_alusrc),
        .i_regwrite (i_regwrite), .i_memwrite (i_memwrite), .i_resultsrc (i_resultsrc),
        .i_row_valid (row_valid), .i_exp_pcsrc (exp_pcsrc),
        .i_exp_pctarget (exp_pctarget), .i_pcsrc (o_pcsrc), .i_pctarget (o_pctarget),
        .i_wb_en (o_wb_en), .i_wb_rd (o_wb_rd), .i_wb_data (o_wb_data),
        .o_errors (errors), .o_checks (checks), .o_pending (pending)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;                    // 40 ns period
    end

    function automatic void add_row(input riscv_pkg::alu_op_t op, input int rs1,
                                    input int rs2, input int rd,
                                    input logic [DATA_WIDTH-1:0] imm, input logic alusrc,
                                    input logic branch, input logic jump,
                                    input logic regwrite, input logic memwrite,
                                    input riscv_pkg::result_src_t rsrc, input logic pcsrc);
        rows.push_back('{op, rs1, rs2, rd, imm, alusrc, branch, jump, regwrite, memwrite,
                         rsrc, pcsrc});
    endfunction

    function automatic void alu_reg(input riscv_pkg::alu_op_t op, input int rd,
                                    input int rs1, input int rs2);
        add_row(op, rs1, rs2, rd, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, riscv_pkg::RES_ALU, 1'b0);
    endfunction

    function automatic void alu_imm(input riscv_pkg::alu_op_t op, input int rd,
                                    input int rs1, input logic [DATA_WIDTH-1:0] imm);
        add_row(op, rs1, 0, rd, imm, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, riscv_pkg::RES_ALU, 1'b0);
    endfunction

    function automatic void bubble_row();
        add_row(riscv_pkg::ALU_ADD, 0, 0, 0, '0, 0, 0, 0, 0, 0, riscv_pkg::RES_ALU, 0);
    endfunction

    function automatic void build_table();
        alu_imm(riscv_pkg::ALU_ADD, 1, 0, 5);
        alu_imm(riscv_pkg::ALU_ADD, 2, 0, 32'hFFFF_FFFD);
        alu_imm(riscv_pkg::ALU_ADD, 3, 0, 32'h8000_0010);
        alu_reg(riscv_pkg::ALU_ADD, 4, 1, 2);          // Distance 3 and 2
        alu_reg(riscv_pkg::ALU_SUB, 5, 4, 3);          // Distance 1 and 2
        alu_reg(riscv_pkg::ALU_AND, 6, 5, 4);
        alu_reg(riscv_pkg::ALU_OR, 7, 3, 6);
        alu_reg(riscv_pkg::ALU_XOR, 8, 7, 2);
        alu_reg(riscv_pkg::ALU_SLL, 9, 3, 1);
        alu_reg(riscv_pkg::ALU_SRL, 10, 3, 1);
        alu_reg(riscv_pkg::ALU_SRA, 11, 3, 1);
        alu_reg(riscv_pkg::ALU_SLT, 12, 2, 1);
        alu_reg(riscv_pkg::ALU_SLTU, 13, 2, 1);
        alu_imm(riscv_pkg::ALU_SUB, 14, 3, 7);
        alu_imm(riscv_pkg::ALU_AND, 15, 3, 32'hF0);
        alu_imm(riscv_pkg::ALU_OR, 16, 2, 32'h100);
        alu_imm(riscv_pkg::ALU_XOR, 17, 1, 32'hFF);
        alu_imm(riscv_pkg::ALU_SLL, 18, 1, 4);
        alu_imm(riscv_pkg::ALU_SRL, 19, 3, 36);        // Only low five bits count
        alu_imm(riscv_pkg::ALU_SRA, 20, 3, 8);
        alu_imm(riscv_pkg::ALU_SLT, 21, 2, 0);
        alu_imm(riscv_pkg::ALU_SLTU, 22, 1, 6);
        add_row(riscv_pkg::ALU_ADD, 0, 4, 0, 32'h40, 1, 0, 0, 0, 1, riscv_pkg::RES_ALU, 0);
        bubble_row();
        add_row(riscv_pkg::ALU_ADD, 0, 0, 23, 32'h40, 1, 0, 0, 1, 0, riscv_pkg::RES_MEM, 0);
        bubble_row();                                  // Load-use gap
        alu_reg(riscv_pkg::ALU_ADD, 24, 23, 1);
        add_row(riscv_pkg::ALU_ADD, 0, 0, 25, 32'h20, 0, 0, 1, 1, 0, riscv_pkg::RES_PC4, 1);
        add_row(riscv_pkg::ALU_SUB, 1, 1, 0, 32'hFFFF_FFF8, 0, 1, 0, 0, 0,
                riscv_pkg::RES_ALU, 1);               // Taken, equal operands
        add_row(riscv_pkg::ALU_SUB, 1, 2, 0, 32'h10, 0, 1, 0, 0, 0, riscv_pkg::RES_ALU, 0);
        add_row(riscv_pkg::ALU_ADD, 1, 0, 0, 32'h7, 1, 0, 0, 0, 0, riscv_pkg::RES_ALU, 0);
        alu_reg(riscv_pkg::ALU_ADD, 26, 0, 0);         // x0 reads zero
        alu_reg(riscv_pkg::ALU_OR, 27, 0, 1);
        for (int i = 0; i < 8; i++) begin              // Random tail, no bubbles
            add_row(riscv_pkg::alu_op_t'($urandom % 10), 1 + $urandom % 9, 1 + $urandom % 9,
                    1 + $urandom % 15, $urandom, $urandom % 2, 0, 0, 1, 0,
                    riscv_pkg::RES_ALU, 0);
        end
    endfunction

    task automatic drive_row(input row_t r, input logic [ADDR_WIDTH-1:0] pc,
                             input logic valid);
        i_rs1_addr   = r.rs1;
        i_rs2_addr   = r.rs2;
        i_rd_addr    = r.rd;
        i_immext     = r.imm;
        i_pc         = pc;
        i_pc4        = pc + 4;
        i_aluctrl    = r.op;
        i_alusrc     = r.alusrc;
        i_branch     = r.branch;
        i_jump       = r.jump;
        i_regwrite   = r.regwrite;
        i_memwrite   = r.memwrite;
        i_resultsrc  = r.rsrc;
        row_valid    = valid;
        exp_pcsrc    = r.exp_pcsrc;
        exp_pctarget = ADDR_WIDTH'(int'(pc) + $signed(r.imm));  // Signed offset, wraps
    endtask

    initial begin
        row_t idle;
        void'($urandom(32'h570));
        i_rst_n = 1'b0;
        idle = '{riscv_pkg::ALU_ADD, 0, 0, 0, '0, 0, 0, 0, 0, 0, riscv_pkg::RES_ALU, 0};
        drive_row(idle, '0, 1'b0);
        build_table();
        repeat (8) @(posedge i_clk);
        #2 i_rst_n = 1'b1;
        foreach (rows[i]) begin
            @(posedge i_clk);
            #2 drive_row(rows[i], ADDR_WIDTH'(i * 4), 1'b1);
        end
        @(posedge i_clk);
        #2 drive_row(idle, '0, 1'b0);
        wait_cnt = 0;
        while (pending && wait_cnt < 20) begin         // Drain with timeout
            @(posedge i_clk);
            wait_cnt++;
        end
        if (pending) begin
            $display("Drain timed out with writebacks still pending");
        end
        $display("errors: %0d  assertion failures: %0d  checks: %0d", errors,
                 exec_backend_inst.checker_inst.fail_count, checks);
        if (pending || errors != 0 || exec_backend_inst.checker_inst.fail_count != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/riscv_pkg.sv
verilog/alu.sv
verilog/forward_unit.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/exec_backend.sv
bench/exec_backend_monitor.sv
bench/exec_backend_checker.sv
bench/tb_exec_backend.sv

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] i_a,             // Operand A, rs1 after forwarding
    input  logic [DATA_WIDTH-1:0] i_b,             // Operand B, rs2 or immediate
    input  riscv_pkg::alu_op_t    i_alucontrol,    // Operation select
    output logic [DATA_WIDTH-1:0] o_result,        // Operation result
    output logic                  o_zero           // High when result is zero
);

    logic [4:0]            shamt;                  // Shift amount from low bits of B
    logic                  lt_signed;              // Signed compare
    logic                  lt_unsigned;            // Unsigned compare
    logic [DATA_WIDTH-1:0] sra_result;             // Arithmetic shift result

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;
    assign sra_result  = $unsigned($signed(i_a) >>> shamt);

    always_comb begin
        case (i_alucontrol)
            riscv_pkg::ALU_ADD:  o_result = i_a + i_b;
            riscv_pkg::ALU_SUB:  o_result = i_a - i_b;     // Used for BEQ/BNE compare
            riscv_pkg::ALU_AND:  o_result = i_a & i_b;
            riscv_pkg::ALU_OR:   o_result = i_a | i_b;
            riscv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            riscv_pkg::ALU_SLL:  o_result = i_a << shamt;
            riscv_pkg::ALU_SRL:  o_result = i_a >> shamt;
            riscv_pkg::ALU_SRA:  o_result = sra_result;
            riscv_pkg::ALU_SLT: begin
                o_result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            end
            riscv_pkg::ALU_SLTU: begin
                o_result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            end
            default:             o_result = '0;            // Unused encodings
        endcase
    end

    // Zero flag feeds branch decision in EX
    assign o_zero = (o_result == '0);

endmodule

/* verilog/exec_backend.sv */
`timescale 1ns/100ps

module exec_backend #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10,
    parameter int MEM_WORDS  = 256
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [4:0]               i_rs1_addr,       // Issue: source 1
    input  logic [4:0]               i_rs2_addr,       // Issue: source 2
    input  logic [4:0]               i_rd_addr,        // Issue: destination
    input  logic [DATA_WIDTH-1:0]    i_immext,
    input  logic [ADDR_WIDTH-1:0]    i_pc,
    input  logic [ADDR_WIDTH-1:0]    i_pc4,
    input  riscv_pkg::alu_op_t       i_aluctrl,
    input  logic                     i_alusrc,
    input  logic                     i_branch,
    input  logic                     i_jump,
    input  logic                     i_regwrite,
    input  logic                     i_memwrite,
    input  riscv_pkg::result_src_t   i_resultsrc,
    output logic                     o_pcsrc,          // Redirect in issue cycle
    output logic [ADDR_WIDTH-1:0]    o_pctarget,
    output logic                     o_wb_en,          // Writeback two cycles after issue
    output logic [4:0]               o_wb_rd,
    output logic [DATA_WIDTH-1:0]    o_wb_data
);

    logic [DATA_WIDTH-1:0]  rs1_data;
    logic [DATA_WIDTH-1:0]  rs2_data;
    logic [DATA_WIDTH-1:0]  alu_result_m;              // Also the MEM forward value
    logic [DATA_WIDTH-1:0]  write_data_m;
    logic                   regwrite_m;
    logic                   memwrite_m;
    riscv_pkg::result_src_t resultsrc_m;
    logic [4:0]             rd_addr_m;
    logic [ADDR_WIDTH-1:0]  pc4_m;
    riscv_pkg::fwd_sel_t    forward_a;
    riscv_pkg::fwd_sel_t    forward_b;

    register_file #(
        .DATA_WIDTH (DATA_WIDTH)
    ) register_file_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (i_rs1_addr),
        .i_rs2_addr (i_rs2_addr),
        .i_rd_addr  (o_wb_rd),
        .i_we       (o_wb_en),
        .i_wd       (o_wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    forward_unit forward_unit_inst (
        .i_rs1_addr_e (i_rs1_addr),
        .i_rs2_addr_e (i_rs2_addr),
        .i_rd_addr_m  (rd_addr_m),
        .i_rd_addr_w  (o_wb_rd),
        .i_regwrite_m (regwrite_m),
        .i_regwrite_w (o_wb_en),
        .o_forward_a  (forward_a),
        .o_forward_b  (forward_b)
    );

    execute_stage #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) execute_stage_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rs1_data_e   (rs1_data),
        .i_rs2_data_e   (rs2_data),
        .i_immext_e     (i_immext),
        .i_pc_e         (i_pc),
        .i_pc4_e        (i_pc4),
        .i_rd_addr_e    (i_rd_addr),
        .i_aluctrl_e    (i_aluctrl),
        .i_alusrc_e     (i_alusrc),
        .i_branch_e     (i_branch),
        .i_jump_e       (i_jump),
        .i_regwrite_e   (i_regwrite),
        .i_memwrite_e   (i_memwrite),
        .i_resultsrc_e  (i_resultsrc),
        .i_forward_m    (alu_result_m),
        .i_forward_w    (o_wb_data),
        .i_forward_a    (forward_a),
        .i_forward_b    (forward_b),
        .o_alu_result_m (alu_result_m),
        .o_write_data_m (write_data_m),
        .o_pctarget_e   (o_pctarget),
        .o_pcsrc_e      (o_pcsrc),
        .o_regwrite_m   (regwrite_m),
        .o_memwrite_m   (memwrite_m),
        .o_resultsrc_m  (resultsrc_m),
        .o_rd_addr_m    (rd_addr_m),
        .o_pc4_m        (pc4_m)
    );

    memory_stage #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) memory_stage_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_alu_result_m (alu_result_m),
        .i_write_data_m (write_data_m),
        .i_rd_addr_m    (rd_addr_m),
        .i_pc4_m        (pc4_m),
        .i_regwrite_m   (regwrite_m),
        .i_memwrite_m   (memwrite_m),
        .i_resultsrc_m  (resultsrc_m),
        .o_result_w     (o_wb_data),
        .o_rd_addr_w    (o_wb_rd),
        .o_regwrite_w   (o_wb_en)
    );

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [DATA_WIDTH-1:0]    i_rs1_data_e,     // From register file
    input  logic [DATA_WIDTH-1:0]    i_rs2_data_e,     // From register file
    input  logic [DATA_WIDTH-1:0]    i_immext_e,       // Sign-extended immediate
    input  logic [ADDR_WIDTH-1:0]    i_pc_e,           // PC of this instruction
    input  logic [ADDR_WIDTH-1:0]    i_pc4_e,          // PC+4, link value
    input  logic [4:0]               i_rd_addr_e,      // Destination register
    input  riscv_pkg::alu_op_t       i_aluctrl_e,      // ALU operation
    input  logic                     i_alusrc_e,       // 1 selects immediate for B
    input  logic                     i_branch_e,       // Conditional branch
    input  logic                     i_jump_e,         // Unconditional jump
    input  logic                     i_regwrite_e,     // Writes rd
    input  logic                     i_memwrite_e,     // Store
    input  riscv_pkg::result_src_t   i_resultsrc_e,    // Writeback source
    input  logic [DATA_WIDTH-1:0]    i_forward_m,      // ALU result in EX/MEM
    input  logic [DATA_WIDTH-1:0]    i_forward_w,      // Result in MEM/WB
    input  riscv_pkg::fwd_sel_t      i_forward_a,      // Operand A source
    input  riscv_pkg::fwd_sel_t      i_forward_b,      // Operand B source
    output logic [DATA_WIDTH-1:0]    o_alu_result_m,   // EX/MEM ALU result
    output logic [DATA_WIDTH-1:0]    o_write_data_m,   // EX/MEM store data
    output logic [ADDR_WIDTH-1:0]    o_pctarget_e,     // Branch/jump target
    output logic                     o_pcsrc_e,        // Redirect, same cycle
    output logic                     o_regwrite_m,
    output logic                     o_memwrite_m,
    output riscv_pkg::result_src_t   o_resultsrc_m,
    output logic [4:0]               o_rd_addr_m,
    output logic [ADDR_WIDTH-1:0]    o_pc4_m
);

    logic [DATA_WIDTH-1:0] src_a;                      // rs1 after forwarding
    logic [DATA_WIDTH-1:0] src_b_reg;                  // rs2 after forwarding
    logic [DATA_WIDTH-1:0] src_b;                      // ALU input B
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  alu_zero;                   // Consumed by branch only

    // Forwarding muxes, MEM over WB is decided in forward_unit
    always_comb begin
        case (i_forward_a)
            riscv_pkg::FWD_MEM: src_a = i_forward_m;
            riscv_pkg::FWD_WB:  src_a = i_forward_w;
            default:            src_a = i_rs1_data_e;
        endcase
        case (i_forward_b)
            riscv_pkg::FWD_MEM: src_b_reg = i_forward_m;
            riscv_pkg::FWD_WB:  src_b_reg = i_forward_w;
            default:            src_b_reg = i_rs2_data_e;
        endcase
    end

    assign src_b = i_alusrc_e ? i_immext_e : src_b_reg;   // Immediate or register

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_inst (
        .i_a          (src_a),
        .i_b          (src_b),
        .i_alucontrol (i_aluctrl_e),
        .o_result     (alu_result),
        .o_zero       (alu_zero)
    );

    // Target is PC relative, immediate truncated to PC width
    assign o_pctarget_e = i_pc_e + i_immext_e[ADDR_WIDTH-1:0];
    assign o_pcsrc_e    = i_jump_e | (i_branch_e & alu_zero);

    // EX/MEM register, loads every cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_alu_result_m <= '0;
            o_write_data_m <= '0;
            o_regwrite_m   <= 1'b0;
            o_memwrite_m   <= 1'b0;
            o_resultsrc_m  <= riscv_pkg::RES_ALU;
            o_rd_addr_m    <= 5'd0;
            o_pc4_m        <= '0;
        end else begin
            o_alu_result_m <= alu_result;
            o_write_data_m <= src_b_reg;               // Forwarded rs2 for stores
            o_regwrite_m   <= i_regwrite_e;
            o_memwrite_m   <= i_memwrite_e;
            o_resultsrc_m  <= i_resultsrc_e;
            o_rd_addr_m    <= i_rd_addr_e;
            o_pc4_m        <= i_pc4_e;
        end
    end

endmodule

/* verilog/forward_unit.sv */
`timescale 1ns/100ps

module forward_unit (
    input  logic [4:0]            i_rs1_addr_e,    // EX source 1
    input  logic [4:0]            i_rs2_addr_e,    // EX source 2
    input  logic [4:0]            i_rd_addr_m,     // Destination in EX/MEM
    input  logic [4:0]            i_rd_addr_w,     // Destination in MEM/WB
    input  logic                  i_regwrite_m,    // EX/MEM writes a register
    input  logic                  i_regwrite_w,    // MEM/WB writes a register
    output riscv_pkg::fwd_sel_t   o_forward_a,     // Select for operand A
    output riscv_pkg::fwd_sel_t   o_forward_b      // Select for operand B
);

    logic mem_wr;                                  // EX/MEM writes a real register
    logic wb_wr;                                   // MEM/WB writes a real register

    assign mem_wr = i_regwrite_m && (i_rd_addr_m != 5'd0);   // x0 never forwarded
    assign wb_wr  = i_regwrite_w && (i_rd_addr_w != 5'd0);

    // MEM checked first, it holds the younger result
    always_comb begin
        if (mem_wr && (i_rd_addr_m == i_rs1_addr_e)) begin
            o_forward_a = riscv_pkg::FWD_MEM;
        end else if (wb_wr && (i_rd_addr_w == i_rs1_addr_e)) begin
            o_forward_a = riscv_pkg::FWD_WB;
        end else begin
            o_forward_a = riscv_pkg::FWD_REG;       // Distance 3 or more
        end
        if (mem_wr && (i_rd_addr_m == i_rs2_addr_e)) begin
            o_forward_b = riscv_pkg::FWD_MEM;
        end else if (wb_wr && (i_rd_addr_w == i_rs2_addr_e)) begin
            o_forward_b = riscv_pkg::FWD_WB;
        end else begin
            o_forward_b = riscv_pkg::FWD_REG;
        end
    end

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10,
    parameter int MEM_WORDS  = 256
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [DATA_WIDTH-1:0]    i_alu_result_m,   // Byte address or ALU value
    input  logic [DATA_WIDTH-1:0]    i_write_data_m,   // Store data
    input  logic [4:0]               i_rd_addr_m,
    input  logic [ADDR_WIDTH-1:0]    i_pc4_m,
    input  logic                     i_regwrite_m,
    input  logic                     i_memwrite_m,
    input  riscv_pkg::result_src_t   i_resultsrc_m,
    output logic [DATA_WIDTH-1:0]    o_result_w,       // Writeback value, also WB forward
    output logic [4:0]               o_rd_addr_w,
    output logic                     o_regwrite_w
);

    localparam int IDX_W = $clog2(MEM_WORDS);          // Word index width

    logic [DATA_WIDTH-1:0]  dmem [MEM_WORDS];          // Word-addressed data memory
    logic [IDX_W-1:0]       word_idx;
    logic [DATA_WIDTH-1:0]  read_data_m;               // Combinational load data
    logic [DATA_WIDTH-1:0]  alu_result_w;
    logic [DATA_WIDTH-1:0]  read_data_w;
    logic [ADDR_WIDTH-1:0]  pc4_w;
    riscv_pkg::result_src_t resultsrc_w;

    assign word_idx    = i_alu_result_m[IDX_W+1:2];    // Drop byte offset
    assign read_data_m = dmem[word_idx];

    // Store lands on the edge that leaves MEM
    always_ff @(posedge i_clk) begin
        if (i_memwrite_m) begin
            dmem[word_idx] <= i_write_data_m;
        end
    end

    // MEM/WB register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            alu_result_w <= '0;
            read_data_w  <= '0;
            pc4_w        <= '0;
            o_rd_addr_w  <= 5'd0;
            o_regwrite_w <= 1'b0;
            resultsrc_w  <= riscv_pkg::RES_ALU;
        end else begin
            alu_result_w <= i_alu_result_m;
            read_data_w  <= read_data_m;
            pc4_w        <= i_pc4_m;
            o_rd_addr_w  <= i_rd_addr_m;
            o_regwrite_w <= i_regwrite_m;
            resultsrc_w  <= i_resultsrc_m;
        end
    end

    // Writeback select, PC+4 zero-extended
    always_comb begin
        case (resultsrc_w)
            riscv_pkg::RES_MEM: o_result_w = read_data_w;
            riscv_pkg::RES_PC4: o_result_w = {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, pc4_w};
            default:            o_result_w = alu_result_w;
        endcase
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/100ps

module register_file #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [4:0]            i_rs1_addr,      // Read port 1 address
    input  logic [4:0]            i_rs2_addr,      // Read port 2 address
    input  logic [4:0]            i_rd_addr,       // Write address
    input  logic                  i_we,            // Write enable from WB
    input  logic [DATA_WIDTH-1:0] i_wd,            // Write data from WB
    output logic [DATA_WIDTH-1:0] o_rs1_data,      // Read port 1 data
    output logic [DATA_WIDTH-1:0] o_rs2_data       // Read port 2 data
);

    logic [DATA_WIDTH-1:0] regs [32];              // x0..x31
    logic                  wr_ok;                  // Write allowed, never x0

    assign wr_ok = i_we && (i_rd_addr != 5'd0);

    // All registers cleared on reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_rd_addr] <= i_wd;               // Written on edge after WB cycle
        end
    end

    // Combinational reads, x0 forced to zero
    always_comb begin
        if (i_rs1_addr == 5'd0) begin
            o_rs1_data = '0;
        end else begin
            o_rs1_data = regs[i_rs1_addr];
        end
        if (i_rs2_addr == 5'd0) begin
            o_rs2_data = '0;
        end else begin
            o_rs2_data = regs[i_rs2_addr];
        end
    end

endmodule

/* verilog/riscv_pkg.sv */
package riscv_pkg;

    // ALU operations, 4-bit encoding
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,      // a + b
        ALU_SUB  = 4'd1,      // a - b, also the branch compare
        ALU_AND  = 4'd2,      // Bitwise and
        ALU_OR   = 4'd3,      // Bitwise or
        ALU_XOR  = 4'd4,      // Bitwise xor
        ALU_SLL  = 4'd5,      // Shift left logical
        ALU_SRL  = 4'd6,      // Shift right logical
        ALU_SRA  = 4'd7,      // Shift right arithmetic
        ALU_SLT  = 4'd8,      // Set less than, signed
        ALU_SLTU = 4'd9       // Set less than, unsigned
    } alu_op_t;

    // Writeback source, chosen in MEM/WB
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,       // ALU result
        RES_MEM = 2'd1,       // Load data
        RES_PC4 = 2'd2        // Link address for jumps
    } result_src_t;

    // Forward choice per EX operand
    // MEM wins over WB when both match
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,       // Value read from register file
        FWD_WB  = 2'd1,       // Result in MEM/WB
        FWD_MEM = 2'd2        // ALU result in EX/MEM
    } fwd_sel_t;

endpackage
